//--- common/gpu_pkg.sv
package gpu_pkg;

  // visible screen and framebuffer geometry
  localparam int SCREEN_W = 32;
  localparam int SCREEN_H = 24;
  localparam int FB_DEPTH = SCREEN_W * SCREEN_H;
  localparam int X_W = 5;
  localparam int Y_W = 5;
  localparam int ADDR_W = 10;

  // raster timing, one pixel per gpu clock
  localparam int H_ACTIVE = 32;
  localparam int H_FRONT = 2;
  localparam int H_SYNC = 4;
  localparam int H_BACK = 2;
  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_ACTIVE = 24;
  localparam int V_FRONT = 1;
  localparam int V_SYNC = 2;
  localparam int V_BACK = 1;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
  localparam int H_SYNC_END = H_SYNC_START + H_SYNC;
  localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
  localparam int V_SYNC_END = V_SYNC_START + V_SYNC;
  localparam int HCOUNT_W = 6;
  localparam int VCOUNT_W = 5;

  // depth and colour
  localparam int Z_W = 8;
  localparam logic [Z_W-1:0] Z_FAR = 8'd255;
  localparam int RGB_W = 12;
  localparam int CH_W = 4;

  // command sequencer states
  localparam logic [1:0] SEQ_IDLE = 2'd0;
  localparam logic [1:0] SEQ_CLEARING = 2'd1;
  localparam logic [1:0] SEQ_SWITCHING = 2'd2;

  // bit 31 selects the view: 0 fragment, 1 control
  typedef union packed {
    struct packed {
      logic op;
      logic spare;
      logic [X_W-1:0] x;
      logic [Y_W-1:0] y;
      logic [Z_W-1:0] z;
      logic [RGB_W-1:0] rgb;
    } frag;
    struct packed {
      logic op;
      logic kind;
      logic [17:0] reserved;
      logic [RGB_W-1:0] clear_rgb;
    } ctrl;
  } cmd_word_u;

endpackage

//--- common/pixel_if.sv
`timescale 1ns/1ps

// one pixel moving between pipeline stages
interface pixel_if;
  import gpu_pkg::*;

  // single-cycle strobe, payload only meaningful while high
  logic valid;
  logic [X_W-1:0] x;
  logic [Y_W-1:0] y;
  logic [Z_W-1:0] z;
  logic [RGB_W-1:0] rgb;

  modport src (
    output valid, x, y, z, rgb
  );

  modport dst (
    input valid, x, y, z, rgb
  );

endinterface

//--- framebuffer/vga_timing.sv
`timescale 1ns/1ps

module vga_timing (
  input  logic gpu_clk_in,
  input  logic rst_in,
  output logic [gpu_pkg::HCOUNT_W-1:0] hcount,
  output logic [gpu_pkg::VCOUNT_W-1:0] vcount,
  output logic active,
  output logic hsync,
  output logic vsync,
  output logic frame_start
);
  import gpu_pkg::*;

  logic h_last;
  logic v_last;

  assign h_last = (hcount == HCOUNT_W'(H_TOTAL - 1));
  assign v_last = (vcount == VCOUNT_W'(V_TOTAL - 1));

  always_ff @(posedge gpu_clk_in) begin
    if (rst_in) begin
      hcount <= '0;
      vcount <= '0;
    end else if (h_last) begin
      hcount <= '0;
      if (v_last) begin
        vcount <= '0;
      end else begin
        vcount <= vcount + 1'b1;
      end
    end else begin
      hcount <= hcount + 1'b1;
    end
  end

  assign active = (hcount < HCOUNT_W'(H_ACTIVE)) && (vcount < VCOUNT_W'(V_ACTIVE));

  // both syncs active low
  assign hsync = !((hcount >= HCOUNT_W'(H_SYNC_START)) &&
                   (hcount < HCOUNT_W'(H_SYNC_END)));
  assign vsync = !((vcount >= VCOUNT_W'(V_SYNC_START)) &&
                   (vcount < VCOUNT_W'(V_SYNC_END)));

  // last pixel of the last line
  assign frame_start = h_last && v_last;

endmodule

//--- framebuffer/framebuffer.sv
`timescale 1ns/1ps

module framebuffer (
  input  logic gpu_clk_in,
  input  logic rst_in,
  pixel_if.dst pix,
  input  logic clear_start,
  input  logic [gpu_pkg::RGB_W-1:0] clear_rgb,
  input  logic swap_req,
  output logic clear_done,
  output logic swap_done,
  output logic hsync_out,
  output logic vsync_out,
  output logic [gpu_pkg::RGB_W-1:0] rgb_out
);
  import gpu_pkg::*;

  logic [RGB_W-1:0] color_mem [2][FB_DEPTH];
  logic [Z_W-1:0] depth_mem [FB_DEPTH];

  logic front_sel;
  logic back_sel;
  logic swap_pend;
  logic swap_fire;

  logic clearing;
  logic [ADDR_W-1:0] clear_addr;
  logic [RGB_W-1:0] clear_color;

  logic [ADDR_W-1:0] pix_addr;
  logic pix_wr;

  logic [HCOUNT_W-1:0] hcount;
  logic [VCOUNT_W-1:0] vcount;
  logic active;
  logic hsync;
  logic vsync;
  logic frame_start;
  logic [ADDR_W-1:0] scan_addr;

  vga_timing vga_timing_inst (
    .gpu_clk_in,
    .rst_in,
    .hcount,
    .vcount,
    .active,
    .hsync,
    .vsync,
    .frame_start
  );

  // power-up contents: black image, far depth
  initial begin
    for (int i = 0; i < FB_DEPTH; i++) begin
      color_mem[0][i] = '0;
      color_mem[1][i] = '0;
      depth_mem[i] = Z_FAR;
    end
  end

  assign back_sel = ~front_sel;
  assign pix_addr = {pix.y, pix.x};
  // depth read and compare in the same cycle as the write
  assign pix_wr = pix.valid && !clearing && (pix.y < Y_W'(SCREEN_H)) &&
                  (pix.z < depth_mem[pix_addr]);
  assign clear_done = clearing && (clear_addr == ADDR_W'(FB_DEPTH - 1));
  assign swap_fire = frame_start && (swap_pend || swap_req);
  assign swap_done = swap_fire;

  always_ff @(posedge gpu_clk_in) begin
    if (clearing) begin
      color_mem[back_sel][clear_addr] <= clear_color;
      depth_mem[clear_addr] <= Z_FAR;
    end else if (pix_wr) begin
      color_mem[back_sel][pix_addr] <= pix.rgb;
      depth_mem[pix_addr] <= pix.z;
    end
  end

  // clear sweep, one address per cycle
  always_ff @(posedge gpu_clk_in) begin
    if (rst_in) begin
      clearing <= 1'b0;
      clear_addr <= '0;
    end else if (clear_start) begin
      clearing <= 1'b1;
      clear_addr <= '0;
    end else if (clearing) begin
      if (clear_done) begin
        clearing <= 1'b0;
      end else begin
        clear_addr <= clear_addr + 1'b1;
      end
    end
  end

  always_ff @(posedge gpu_clk_in) begin
    if (clear_start) begin
      clear_color <= clear_rgb;
    end
  end

  // swap waits for the end of the frame
  always_ff @(posedge gpu_clk_in) begin
    if (rst_in) begin
      swap_pend <= 1'b0;
      front_sel <= 1'b0;
    end else begin
      if (swap_fire) begin
        swap_pend <= 1'b0;
        front_sel <= ~front_sel;
      end else if (swap_req) begin
        swap_pend <= 1'b1;
      end
    end
  end

  // scan-out, one cycle behind the counters
  assign scan_addr = {vcount, hcount[X_W-1:0]};

  always_ff @(posedge gpu_clk_in) begin
    if (rst_in) begin
      hsync_out <= 1'b1;
      vsync_out <= 1'b1;
      rgb_out <= '0;
    end else begin
      hsync_out <= hsync;
      vsync_out <= vsync;
      rgb_out <= active ? color_mem[front_sel][scan_addr] : '0;
    end
  end

endmodule

//--- src/fragment_shader.sv
`timescale 1ns/1ps

module fragment_shader (
  input logic gpu_clk_in,
  input logic rst_in,
  pixel_if.dst frag,
  pixel_if.src pix
);
  import gpu_pkg::*;

  logic [CH_W:0] fog_scale;
  logic [RGB_W-1:0] fog_rgb;

  // channel scaled by fog factor, then divided by 16
  function automatic logic [CH_W-1:0] fog_channel(input logic [CH_W-1:0] ch,
                                                  input logic [CH_W:0] scale);
    logic [2*CH_W:0] prod;
    prod = ch * scale;
    return CH_W'(prod >> CH_W);
  endfunction

  // near fragments get 16, the farthest get 1
  assign fog_scale = {1'b1, {CH_W{1'b0}}} - {1'b0, frag.z[Z_W-1 -: CH_W]};

  always_comb begin
    for (int i = 0; i < RGB_W / CH_W; i++) begin
      fog_rgb[i*CH_W +: CH_W] = fog_channel(frag.rgb[i*CH_W +: CH_W], fog_scale);
    end
  end

  always_ff @(posedge gpu_clk_in) begin
    if (rst_in) begin
      pix.valid <= 1'b0;
    end else begin
      pix.valid <= frag.valid;
    end
  end

  always_ff @(posedge gpu_clk_in) begin
    pix.x <= frag.x;
    pix.y <= frag.y;
    pix.z <= frag.z;
    pix.rgb <= fog_rgb;
  end

endmodule

//--- src/graphics.sv
`timescale 1ns/1ps

module graphics (
  input  logic gpu_clk_in,
  input  logic rst_in,
  input  logic cmd_valid,
  input  logic [31:0] cmd_word,
  output logic busy,
  output logic hsync_out,
  output logic vsync_out,
  output logic [gpu_pkg::RGB_W-1:0] rgb_out
);
  import gpu_pkg::*;

  cmd_word_u cmd;
  logic accept;
  logic [1:0] seq_state;

  // control pulses, two stages to line up with the fragment path
  logic clear_p1;
  logic clear_p2;
  logic swap_p1;
  logic swap_p2;
  logic [RGB_W-1:0] clear_color;

  logic clear_done;
  logic swap_done;

  pixel_if frag_bus ();
  pixel_if pix_bus ();

  assign cmd = cmd_word;
  assign accept = cmd_valid && !busy;
  assign busy = (seq_state != SEQ_IDLE);

  // fragment words go straight onto the fragment bus
  always_ff @(posedge gpu_clk_in) begin
    if (rst_in) begin
      frag_bus.valid <= 1'b0;
    end else begin
      frag_bus.valid <= accept && !cmd.frag.op;
    end
  end

  always_ff @(posedge gpu_clk_in) begin
    frag_bus.x <= cmd.frag.x;
    frag_bus.y <= cmd.frag.y;
    frag_bus.z <= cmd.frag.z;
    frag_bus.rgb <= cmd.frag.rgb;
  end

  // clear colour from the accepted control word, held while busy
  always_ff @(posedge gpu_clk_in) begin
    if (accept && cmd.ctrl.op && !cmd.ctrl.kind) begin
      clear_color <= cmd.ctrl.clear_rgb;
    end
  end

  always_ff @(posedge gpu_clk_in) begin
    if (rst_in) begin
      clear_p1 <= 1'b0;
      clear_p2 <= 1'b0;
      swap_p1 <= 1'b0;
      swap_p2 <= 1'b0;
    end else begin
      clear_p1 <= accept && cmd.ctrl.op && !cmd.ctrl.kind;
      swap_p1 <= accept && cmd.ctrl.op && cmd.ctrl.kind;
      clear_p2 <= clear_p1;
      swap_p2 <= swap_p1;
    end
  end

  // sequencer holds busy until the framebuffer reports completion
  always_ff @(posedge gpu_clk_in) begin
    if (rst_in) begin
      seq_state <= SEQ_IDLE;
    end else begin
      case (seq_state)
        SEQ_IDLE: begin
          if (accept && cmd.ctrl.op) begin
            seq_state <= cmd.ctrl.kind ? SEQ_SWITCHING : SEQ_CLEARING;
          end
        end
        SEQ_CLEARING: begin
          if (clear_done) begin
            seq_state <= SEQ_IDLE;
          end
        end
        SEQ_SWITCHING: begin
          if (swap_done) begin
            seq_state <= SEQ_IDLE;
          end
        end
        default: seq_state <= SEQ_IDLE;
      endcase
    end
  end

  fragment_shader fragment_shader_inst (
    .gpu_clk_in,
    .rst_in,
    .frag(frag_bus),
    .pix(pix_bus)
  );

  framebuffer framebuffer_inst (
    .gpu_clk_in,
    .rst_in,
    .pix(pix_bus),
    .clear_start(clear_p2),
    .clear_rgb(clear_color),
    .swap_req(swap_p2),
    .clear_done,
    .swap_done,
    .hsync_out,
    .vsync_out,
    .rgb_out
  );

endmodule

//--- verification/graphics_sva.sv
`timescale 1ns/1ps

module graphics_sva (
  input logic gpu_clk_in,
  input logic rst_in,
  input logic clearing,
  input logic pix_valid,
  input logic [gpu_pkg::ADDR_W-1:0] clear_addr,
  input logic swap_done,
  input logic [gpu_pkg::HCOUNT_W-1:0] hcount,
  input logic [gpu_pkg::VCOUNT_W-1:0] vcount,
  input logic hsync_out,
  input logic vsync_out
);
  import gpu_pkg::*;

  // busy hold-off keeps fragments out of the clear sweep
  assert property (@(posedge gpu_clk_in) disable iff (rst_in) !(clearing && pix_valid))
    else $error("pixel write strobe during clear sweep");

  assert property (@(posedge gpu_clk_in) disable iff (rst_in)
                   clear_addr < ADDR_W'(FB_DEPTH))
    else $error("clear address out of range");

  // buffer swap only on the last cycle of a frame
  assert property (@(posedge gpu_clk_in) disable iff (rst_in)
                   swap_done |=> (hcount == '0 && vcount == '0))
    else $error("swap_done away from the frame boundary");

  assert property (@(posedge gpu_clk_in) rst_in |=> (hsync_out && vsync_out))
    else $error("sync outputs not idle after reset");

endmodule

bind framebuffer graphics_sva graphics_sva_inst (
  .gpu_clk_in(gpu_clk_in),
  .rst_in(rst_in),
  .clearing(clearing),
  .pix_valid(pix.valid),
  .clear_addr(clear_addr),
  .swap_done(swap_done),
  .hcount(hcount),
  .vcount(vcount),
  .hsync_out(hsync_out),
  .vsync_out(vsync_out)
);

//--- verification/graphics_tb.sv
`timescale 1ns/1ps

module graphics_tb;
  import gpu_pkg::*;

  localparam int WAIT_LIMIT = 4000;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

  logic gpu_clk_in;
  logic rst_in;
  logic cmd_valid;
  logic [31:0] cmd_word;
  logic busy;
  logic hsync_out;
  logic vsync_out;
  logic [RGB_W-1:0] rgb_out;

  // reference image state
  logic [RGB_W-1:0] model_color [2][FB_DEPTH];
  logic [Z_W-1:0] model_depth [FB_DEPTH];
  logic model_front;

  graphics graphics_inst (
    .gpu_clk_in,
    .rst_in,
    .cmd_valid,
    .cmd_word,
    .busy,
    .hsync_out,
    .vsync_out,
    .rgb_out
  );

  initial begin
    gpu_clk_in = 1'b0;
    forever #10 gpu_clk_in = ~gpu_clk_in;
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  // fog: channel times (16 - top nibble of z), divided by 16
  function automatic logic [RGB_W-1:0] fog_color(input logic [Z_W-1:0] z,
                                                 input logic [RGB_W-1:0] rgb);
    int scale;
    logic [RGB_W-1:0] res;
    scale = 16 - int'(z[Z_W-1 -: 4]);
    for (int i = 0; i < 3; i++) begin
      res[i*4 +: 4] = 4'((int'(rgb[i*4 +: 4]) * scale) / 16);
    end
    return res;
  endfunction

  function automatic logic [31:0] frag_cmd(input logic [X_W-1:0] x, input logic [Y_W-1:0] y,
                                           input logic [Z_W-1:0] z,
                                           input logic [RGB_W-1:0] rgb);
    cmd_word_u w;
    w = '0;
    w.frag.x = x;
    w.frag.y = y;
    w.frag.z = z;
    w.frag.rgb = rgb;
    return w;
  endfunction

  function automatic logic [31:0] ctrl_cmd(input logic kind, input logic [RGB_W-1:0] rgb);
    cmd_word_u w;
    w = '0;
    w.ctrl.op = 1'b1;
    w.ctrl.kind = kind;
    w.ctrl.clear_rgb = rgb;
    return w;
  endfunction

  task automatic model_apply(input logic [31:0] word);
    cmd_word_u w;
    logic back;
    int a;
    w = word;
    back = ~model_front;
    if (!w.frag.op) begin
      a = int'(w.frag.y) * SCREEN_W + int'(w.frag.x);
      if (w.frag.z < model_depth[a]) begin
        model_color[back][a] = fog_color(w.frag.z, w.frag.rgb);
        model_depth[a] = w.frag.z;
      end
    end else if (!w.ctrl.kind) begin
      for (int i = 0; i < FB_DEPTH; i++) begin
        model_color[back][i] = w.ctrl.clear_rgb;
        model_depth[i] = Z_FAR;
      end
    end else begin
      model_front = back;
    end
  endtask

  // one command for one cycle, accepted if busy is low in that cycle
  task automatic present(input logic [31:0] w, output logic taken);
    @(posedge gpu_clk_in);
    cmd_valid <= 1'b1;
    cmd_word <= w;
    @(negedge gpu_clk_in);
    taken = !busy;
    if (taken) begin
      model_apply(w);
    end
  endtask

  task automatic release_bus();
    @(posedge gpu_clk_in);
    cmd_valid <= 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    @(negedge gpu_clk_in);
    while (busy && n < WAIT_LIMIT) begin
      @(negedge gpu_clk_in);
      n++;
    end
    assert (!busy) else stop_with_error("timed out waiting for busy to fall");
  endtask

  task automatic control(input logic [31:0] w);
    logic taken;
    present(w, taken);
    release_bus();
    assert (taken) else stop_with_error($sformatf("MISMATCH at %0t: control %h dropped",
                                                  $time, w));
    wait_idle();
  endtask

  // random fragments, with some repeats at the same pixel and depth
  task automatic draw_random(input int count);
    cmd_word_u w;
    logic taken;
    w = '0;
    for (int i = 0; i < count; i++) begin
      if (i == 0 || $urandom_range(3) != 0) begin
        w = frag_cmd(X_W'($urandom_range(SCREEN_W - 1)), Y_W'($urandom_range(SCREEN_H - 1)),
                     Z_W'($urandom), RGB_W'($urandom));
      end else begin
        w.frag.rgb = RGB_W'($urandom);
      end
      present(w, taken);
      assert (taken) else stop_with_error($sformatf("MISMATCH at %0t: fragment dropped", $time));
    end
    release_bus();
  endtask

  // lock onto the vsync falling edge, then check every output sample
  task automatic capture_frames(input int frames);
    int h;
    int v;
    int n;
    logic exp_hs;
    logic exp_vs;
    logic [RGB_W-1:0] exp_rgb;
    n = 0;
    @(negedge gpu_clk_in);
    while (!vsync_out && n < WAIT_LIMIT) begin
      @(negedge gpu_clk_in);
      n++;
    end
    while (vsync_out && n < WAIT_LIMIT) begin
      @(negedge gpu_clk_in);
      n++;
    end
    assert (!vsync_out) else stop_with_error("timed out waiting for vsync");
    h = 0;
    v = V_ACTIVE + V_FRONT;
    for (int s = 0; s < frames * FRAME_CYCLES; s++) begin
      if (s > 0) begin
        @(negedge gpu_clk_in);
        h = (h == H_TOTAL - 1) ? 0 : h + 1;
        if (h == 0) begin
          v = (v == V_TOTAL - 1) ? 0 : v + 1;
        end
      end
      exp_hs = !(h >= H_ACTIVE + H_FRONT && h < H_ACTIVE + H_FRONT + H_SYNC);
      exp_vs = !(v >= V_ACTIVE + V_FRONT && v < V_ACTIVE + V_FRONT + V_SYNC);
      exp_rgb = (h < H_ACTIVE && v < V_ACTIVE) ? model_color[model_front][v * SCREEN_W + h] : '0;
      assert (hsync_out == exp_hs && vsync_out == exp_vs && rgb_out == exp_rgb)
        else stop_with_error($sformatf(
          "MISMATCH at %0t: h %0d v %0d got hs %b vs %b rgb %h, expected hs %b vs %b rgb %h",
          $time, h, v, hsync_out, vsync_out, rgb_out, exp_hs, exp_vs, exp_rgb));
    end
  endtask

  initial begin
    logic taken;
    logic [31:0] w;
    void'($urandom(60));
    rst_in = 1'b1;
    cmd_valid = 1'b0;
    cmd_word = '0;
    for (int i = 0; i < FB_DEPTH; i++) begin
      model_color[0][i] = '0;
      model_color[1][i] = '0;
      model_depth[i] = Z_FAR;
    end
    model_front = 1'b0;
    repeat (2) @(posedge gpu_clk_in);
    rst_in <= 1'b0;
    @(negedge gpu_clk_in);
    assert (!busy) else stop_with_error($sformatf("MISMATCH at %0t: busy after reset", $time));

    // blank image and raster timing over two frames
    capture_frames(2);

    // clear then switch
    control(ctrl_cmd(1'b0, RGB_W'($urandom)));
    control(ctrl_cmd(1'b1, '0));
    capture_frames(1);

    // random fragments with fog and depth test
    control(ctrl_cmd(1'b0, RGB_W'($urandom)));
    draw_random(400);
    control(ctrl_cmd(1'b1, '0));
    capture_frames(1);

    // draw into the back buffer while the front one is shown
    control(ctrl_cmd(1'b0, RGB_W'($urandom)));
    fork
      capture_frames(1);
      draw_random(1200);
    join
    control(ctrl_cmd(1'b1, '0));
    capture_frames(1);

    // commands during a clear sweep are dropped
    present(ctrl_cmd(1'b0, RGB_W'($urandom)), taken);
    assert (taken) else stop_with_error($sformatf("MISMATCH at %0t: clear dropped", $time));
    for (int i = 0; i < 8; i++) begin
      if (i == 3) begin
        w = ctrl_cmd(1'b1, '0);
      end else if (i == 6) begin
        w = ctrl_cmd(1'b0, RGB_W'($urandom));
      end else begin
        w = frag_cmd(X_W'($urandom_range(SCREEN_W - 1)), Y_W'($urandom_range(SCREEN_H - 1)),
                     '0, RGB_W'($urandom));
      end
      present(w, taken);
      assert (!taken)
        else stop_with_error($sformatf("MISMATCH at %0t: %h accepted while busy", $time, w));
    end
    release_bus();
    wait_idle();
    control(ctrl_cmd(1'b1, '0));
    capture_frames(1);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- files.f
common/gpu_pkg.sv
common/pixel_if.sv
framebuffer/vga_timing.sv
framebuffer/framebuffer.sv
src/fragment_shader.sv
src/graphics.sv
verification/graphics_sva.sv
verification/graphics_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile with Verilator, run, and search the log for the failure line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module graphics_tb -f files.f \
  || { echo "build failed"; exit 1; }
./obj_dir/Vgraphics_tb > sim.log 2>&1 || echo "simulation exited with an error"
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0
